//--- alg1a_top.f
src/alg1a_cfg_pkg.sv
src/alg1a_bus_pkg.sv
src/alg1a_seq_fsm.sv
src/alg1a_req_issue.sv
src/alg1a_wr_resp_track.sv
src/alg1a_rd_check.sv
src/alg1a_top.sv
dv/alg1a_checker.sv
dv/tb_alg1a.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the alg1a testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary -f alg1a_top.f --top-module tb_alg1a -Mdir obj_dir -o Vtb_alg1a
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vtb_alg1a > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -q "^TB PASSED$" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1

//--- dv/tb_alg1a.sv
/*
  testbench for alg1a_top
  memory model answers each accepted request one cycle later, in order
  request ready is random, counts in the table stay small so totals fit 8 bits
  corrupt rows flip bit 0 of one read, err_set counts sets over the whole run
*/
`default_nettype none

module tb_alg1a;
  import alg1a_cfg_pkg::*;
  import alg1a_bus_pkg::*;

  localparam int NUM_TESTS = 6;

  typedef struct {
    t_alg_cfg cfg;
    int       err_set;   // -1 for no corrupt read
    int       err_k;     // read index within that set
    int       slv_idx;   // write ordinal answered with slverr, -1 for none
  } t_row;

  typedef struct {
    logic              is_wr;
    logic              slv;
    logic [DATA_W-1:0] data;
  } t_resp;

  logic        i_clk;
  logic        i_arst_n;
  logic        i_start;
  t_alg_cfg    i_cfg;
  logic        o_busy;
  logic        o_done;
  t_alg_status o_status;
  logic [CNT_W-1:0] o_loop_count;
  logic [CNT_W-1:0] o_set_count;
  t_mem_req    o_mem_req;
  logic        o_req_valid;
  logic        i_req_ready;
  t_wr_resp    i_wr_resp;
  t_rd_resp    i_rd_resp;

  t_row              table_rows [NUM_TESTS];
  t_resp             pend [$];     // responses waiting one cycle
  t_resp             resp;
  logic [DATA_W-1:0] mem [logic [ADDR_W-1:0]];
  int                seed;
  int                cycles;
  int                cycle_limit;
  int                test_id;
  int                err_set;
  int                err_k;
  int                slv_idx;
  int                corrupt_ord;  // read ordinal to flip
  int                wr_seen;
  int                rd_seen;
  int                pass_cnt;
  int                fail_cnt;

  alg1a_top dut0
  (
    .i_clk        ( i_clk        ),
    .i_arst_n     ( i_arst_n     ),
    .i_start      ( i_start      ),
    .i_cfg        ( i_cfg        ),
    .o_busy       ( o_busy       ),
    .o_done       ( o_done       ),
    .o_status     ( o_status     ),
    .o_loop_count ( o_loop_count ),
    .o_set_count  ( o_set_count  ),
    .o_mem_req    ( o_mem_req    ),
    .o_req_valid  ( o_req_valid  ),
    .i_req_ready  ( i_req_ready  ),
    .i_wr_resp    ( i_wr_resp    ),
    .i_rd_resp    ( i_rd_resp    )
  );

  alg1a_checker u_checker
  (
    .i_clk        ( i_clk        ),
    .i_arst_n     ( i_arst_n     ),
    .i_start      ( i_start      ),
    .i_cfg        ( i_cfg        ),
    .i_test_id    ( test_id      ),
    .i_err_set    ( err_set      ),
    .i_err_k      ( err_k        ),
    .i_slv_idx    ( slv_idx      ),
    .i_busy       ( o_busy       ),
    .i_done       ( o_done       ),
    .i_status     ( o_status     ),
    .i_loop_count ( o_loop_count ),
    .i_set_count  ( o_set_count  ),
    .i_mem_req    ( o_mem_req    ),
    .i_req_valid  ( o_req_valid  ),
    .i_req_ready  ( i_req_ready  ),
    .o_pass_cnt   ( pass_cnt     ),
    .o_fail_cnt   ( fail_cnt     )
  );

  always #4 i_clk = !i_clk;  // period 8

  function automatic int eff(input logic [CNT_W-1:0] v);
    return (v == '0) ? 1 : int'(v);
  endfunction

  function automatic t_row make_row(input logic [31:0] base, input logic [31:0] pat,
                                    input logic [15:0] inc, input logic [31:0] off,
                                    input int n, input int s, input int l, input logic pp,
                                    input int e_set, input int e_k, input int slv);
    t_row r;
    r.cfg = '{base_addr: base, base_pattern: pat, addr_inc: inc, set_offset: off,
              num_incr: CNT_W'(n), num_sets: CNT_W'(s), num_loops: CNT_W'(l),
              pattern_param: pp};
    r.err_set = e_set;
    r.err_k   = e_k;
    r.slv_idx = slv;
    return r;
  endfunction

  // memory model sees the request as it will transfer on the next rising edge
  always @(negedge i_clk)
  begin
    i_wr_resp = '0;
    i_rd_resp = '0;
    if (pend.size() > 0)
    begin
      resp = pend.pop_front();
      if (resp.is_wr)
        i_wr_resp = '{valid: 1'b1, slverr: resp.slv};
      else
        i_rd_resp = '{valid: 1'b1, data: resp.data};
    end
    i_req_ready = ($random(seed) & 3) != 0;  // ready for the coming edge
    if (o_req_valid && i_req_ready)
    begin
      resp.is_wr = o_mem_req.is_write;
      resp.slv   = o_mem_req.is_write && (wr_seen == slv_idx);
      if (o_mem_req.is_write)
      begin
        mem[o_mem_req.addr] = o_mem_req.data;
        resp.data = '0;
        wr_seen++;
      end
      else
      begin
        resp.data = mem.exists(o_mem_req.addr) ? mem[o_mem_req.addr] : '0;
        if (rd_seen == corrupt_ord)
          resp.data = resp.data ^ 32'h1;
        rd_seen++;
      end
      pend.push_back(resp);
    end
  end

  always @(posedge i_clk)
  begin
    cycles++;
    if (cycles > cycle_limit)
    begin
      $display("timeout: no o_done from test %0d after %0d cycles", test_id, cycles);
      $display("TB FAILED");
      $finish;
    end
  end

  initial
  begin
    seed        = 32'h6b3ed9cc;
    i_clk       = 1'b0;
    i_arst_n    = 1'b0;
    i_start     = 1'b0;
    i_cfg       = '0;
    i_req_ready = 1'b0;
    i_wr_resp   = '0;
    i_rd_resp   = '0;
    cycles      = 0;
    test_id     = -1;
    err_set     = -1;
    err_k       = 0;
    slv_idx     = -1;
    corrupt_ord = -1;
    wr_seen     = 0;
    rd_seen     = 0;

    // base, pattern, inc, offset, N, sets, loops, pattern param, corrupt set/k, slverr
    table_rows[0] = make_row(32'h1000, 32'ha5a50000, 16'd4, 32'h100, 4, 3, 2, 1'b1, -1, 0, -1);
    table_rows[1] = make_row(32'h8000, 32'h12345678, 16'd8, 32'h40, 5, 2, 3, 1'b0, -1, 0, 3);
    table_rows[2] = make_row(32'h2000, 32'hffff_fffe, 16'd4, 32'h20, 3, 2, 1, 1'b1, -1, 0, -1);
    table_rows[3] = make_row(32'h3000, 32'h0f0f0f0f, 16'd4, 32'h80, 4, 2, 2, 1'b1, 2, 1, -1);
    table_rows[4] = make_row(32'h0040, 32'hdeadbeef, 16'd0, 32'h0, 0, 0, 0, 1'b1, -1, 0, -1);
    table_rows[5] = make_row(32'h4000, 32'h55aa55aa, 16'd12, 32'h100, 6, 2, 2, 1'b0, 0, 5, 2);

    cycle_limit = 200;  // reset and gaps
    foreach (table_rows[i])
      cycle_limit += eff(table_rows[i].cfg.num_loops) * eff(table_rows[i].cfg.num_sets)
                     * eff(table_rows[i].cfg.num_incr) * 8 + 50;

    repeat (4) @(negedge i_clk);
    i_arst_n = 1'b1;
    @(negedge i_clk);

    for (int i = 0; i < NUM_TESTS; i++)
    begin
      @(negedge i_clk);
      test_id     = i;
      err_set     = table_rows[i].err_set;
      err_k       = table_rows[i].err_k;
      slv_idx     = table_rows[i].slv_idx;
      corrupt_ord = (err_set >= 0) ? err_set * eff(table_rows[i].cfg.num_incr) + err_k : -1;
      wr_seen     = 0;
      rd_seen     = 0;
      i_cfg       = table_rows[i].cfg;
      i_start     = 1'b1;
      @(negedge i_clk);
      i_start = 1'b0;
      do
        @(negedge i_clk);
      while (!o_done);
      repeat (2) @(negedge i_clk);
    end

    repeat (4) @(negedge i_clk);
    $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
    if ((fail_cnt == 0) && (pass_cnt == NUM_TESTS))
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- dv/alg1a_checker.sv
/*
  watches the alg1a ports and compares against a model of the test rules
  samples on the rising edge, inputs must be driven on the falling edge
  expects one run at a time, started only while o_busy is low
  err_set is a run wide set index (loop * sets + set), -1 for none
*/
`default_nettype none

module alg1a_checker
(
  input  logic                            i_clk,
  input  logic                            i_arst_n,
  input  logic                            i_start,
  input  alg1a_cfg_pkg::t_alg_cfg         i_cfg,
  input  int                              i_test_id,
  input  int                              i_err_set,
  input  int                              i_err_k,
  input  int                              i_slv_idx,
  input  logic                            i_busy,
  input  logic                            i_done,
  input  alg1a_cfg_pkg::t_alg_status      i_status,
  input  logic [alg1a_cfg_pkg::CNT_W-1:0] i_loop_count,
  input  logic [alg1a_cfg_pkg::CNT_W-1:0] i_set_count,
  input  alg1a_bus_pkg::t_mem_req         i_mem_req,
  input  logic                            i_req_valid,
  input  logic                            i_req_ready,
  output int                              o_pass_cnt,
  output int                              o_fail_cnt
);
  import alg1a_cfg_pkg::*;
  import alg1a_bus_pkg::*;

  t_alg_cfg cfg;       // latched at start
  int       n_cnt;
  int       s_cnt;
  int       l_cnt;
  int       err_set;
  int       err_k;
  int       slv_idx;
  int       test_id;
  int       wr_ord;    // writes seen this run
  int       rd_ord;
  int       total;     // requests of each kind expected
  int       errs;
  logic     in_run;
  logic     first_cyc;

  function automatic int eff(input logic [CNT_W-1:0] v);
    return (v == '0) ? 1 : int'(v);
  endfunction

  function automatic logic [DATA_W-1:0] exp_pattern(input int loop);
    return cfg.pattern_param ? cfg.base_pattern + DATA_W'(loop) : cfg.base_pattern;
  endfunction

  // ordinal counts requests of one kind over the run
  function automatic logic [ADDR_W-1:0] exp_addr(input int ord);
    int set;
    int n;
    set = (ord / n_cnt) % s_cnt;
    n   = ord % n_cnt;
    return cfg.base_addr + ADDR_W'(set) * cfg.set_offset
           + ADDR_W'(n) * ADDR_W'(cfg.addr_inc);
  endfunction

  task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp)
    begin
      $display("CHECK FAILED test %0d %s got %h expected %h", test_id, name, got, exp);
      errs++;
    end
  endtask

  task automatic complain(input string what);
    $display("test %0d error: %s", test_id, what);
    errs++;
  endtask

  task automatic check_request();
    int loop;
    if (i_mem_req.is_write)
    begin
      loop = wr_ord / (n_cnt * s_cnt);
      if (wr_ord >= total)
        complain("write issued past the last expected set");
      else if (rd_ord != (wr_ord / n_cnt) * n_cnt)
        complain("write issued before the verify phase of the previous set ended");
      compare("o_mem_req.addr", 64'(i_mem_req.addr), 64'(exp_addr(wr_ord)));
      compare("o_mem_req.data", 64'(i_mem_req.data), 64'(exp_pattern(loop)));
      wr_ord++;
    end
    else
    begin
      if (rd_ord >= total)
        complain("read issued past the last expected set");
      else if (wr_ord != (rd_ord / n_cnt + 1) * n_cnt)
        complain("read issued outside the verify phase of its set");
      compare("o_mem_req.addr", 64'(i_mem_req.addr), 64'(exp_addr(rd_ord)));
      compare("o_mem_req.data", 64'(i_mem_req.data), 64'(0));
      rd_ord++;
    end
  endtask

  task automatic finish_run();
    int ord;
    compare("o_busy", 64'(i_busy), 64'(0));  // falls with done
    compare("write count", 64'(wr_ord), 64'(total));
    compare("read count", 64'(rd_ord), 64'(total));
    compare("o_status.slverr", 64'(i_status.slverr),
            64'((slv_idx >= 0) && (slv_idx < total)));
    if (err_set >= 0)
    begin
      ord = err_set * n_cnt + err_k;
      compare("o_status.error_found", 64'(i_status.error_found), 64'(1));
      compare("o_status.error_addr", 64'(i_status.error_addr), 64'(exp_addr(ord)));
      compare("o_status.expected", 64'(i_status.expected),
              64'(exp_pattern(err_set / s_cnt)));
      compare("o_status.received", 64'(i_status.received),
              64'(exp_pattern(err_set / s_cnt) ^ 32'h1));
      compare("o_loop_count", 64'(i_loop_count), 64'(err_set / s_cnt));
      compare("o_set_count", 64'(i_set_count), 64'(err_set % s_cnt));
    end
    else
    begin
      compare("o_status.error_found", 64'(i_status.error_found), 64'(0));
      compare("o_loop_count", 64'(i_loop_count), 64'(l_cnt));  // totals at done
      compare("o_set_count", 64'(i_set_count), 64'(s_cnt));
    end
    if (errs == 0)
    begin
      $display("test %0d ok: %0d writes, %0d reads", test_id, wr_ord, rd_ord);
      o_pass_cnt++;
    end
    else
    begin
      $display("test %0d failed with %0d errors", test_id, errs);
      o_fail_cnt++;
    end
    in_run = 1'b0;
  endtask

  always @(posedge i_clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      in_run     = 1'b0;
      first_cyc  = 1'b0;
      o_pass_cnt = 0;
      o_fail_cnt = 0;
    end
    else if (i_start && !i_busy && !in_run)
    begin
      cfg       = i_cfg;
      n_cnt     = eff(i_cfg.num_incr);
      s_cnt     = eff(i_cfg.num_sets);
      l_cnt     = eff(i_cfg.num_loops);
      err_set   = i_err_set;
      err_k     = i_err_k;
      slv_idx   = i_slv_idx;
      test_id   = i_test_id;
      total     = (err_set >= 0) ? (err_set + 1) * n_cnt : l_cnt * s_cnt * n_cnt;
      wr_ord    = 0;
      rd_ord    = 0;
      errs      = 0;
      in_run    = 1'b1;
      first_cyc = 1'b1;
    end
    else if (in_run)
    begin
      if (first_cyc)
      begin
        // status fields cleared by the start
        compare("o_busy", 64'(i_busy), 64'(1));
        compare("o_status.slverr", 64'(i_status.slverr), 64'(0));
        compare("o_status.error_found", 64'(i_status.error_found), 64'(0));
        first_cyc = 1'b0;
      end
      else if (!i_done)
        compare("o_busy", 64'(i_busy), 64'(1));
      if (i_req_valid && i_req_ready)
        check_request();
      if (i_done)
        finish_run();
    end
    else if (i_done)
    begin
      $display("o_done pulsed outside a run after test %0d", test_id);
      o_fail_cnt++;
    end
  end

endmodule

`default_nettype wire

//--- src/alg1a_top.sv
/*
  algorithm 1a memory test engine, self checking only
  memory must return responses in request order and never drop one
  o_status holds from o_done until the next i_start
*/
`default_nettype none

module alg1a_top
(
  input  logic                            i_clk,
  input  logic                            i_arst_n,
  input  logic                            i_start,
  input  alg1a_cfg_pkg::t_alg_cfg         i_cfg,
  output logic                            o_busy,
  output logic                            o_done,
  output alg1a_cfg_pkg::t_alg_status      o_status,
  output logic [alg1a_cfg_pkg::CNT_W-1:0] o_loop_count,
  output logic [alg1a_cfg_pkg::CNT_W-1:0] o_set_count,
  output alg1a_bus_pkg::t_mem_req         o_mem_req,
  output logic                            o_req_valid,
  input  logic                            i_req_ready,
  input  alg1a_bus_pkg::t_wr_resp         i_wr_resp,
  input  alg1a_bus_pkg::t_rd_resp         i_rd_resp
);
  import alg1a_cfg_pkg::*;

  logic              phase_start;
  logic              phase_write;
  logic              wr_track_start;
  logic              rd_check_start;
  logic              clear;        // start of a run
  logic [DATA_W-1:0] pattern;      // P
  logic [ADDR_W-1:0] set_base;     // X
  logic [CNT_W-1:0]  num_incr;     // N, never 0
  logic [INC_W-1:0]  addr_inc;
  logic              wr_done;
  logic              rd_done;
  logic              set_error;
  logic              slverr;
  logic              error_found;
  logic [ADDR_W-1:0] error_addr;
  logic [DATA_W-1:0] expected;
  logic [DATA_W-1:0] received;

  alg1a_seq_fsm u_seq_fsm
  (
    .i_clk            ( i_clk          ),
    .i_arst_n         ( i_arst_n       ),
    .i_start          ( i_start        ),
    .i_cfg            ( i_cfg          ),
    .i_wr_done        ( wr_done        ),
    .i_rd_done        ( rd_done        ),
    .i_set_error      ( set_error      ),
    .o_phase_start    ( phase_start    ),
    .o_phase_write    ( phase_write    ),
    .o_wr_track_start ( wr_track_start ),
    .o_rd_check_start ( rd_check_start ),
    .o_pattern        ( pattern        ),
    .o_set_base       ( set_base       ),
    .o_num_incr       ( num_incr       ),
    .o_addr_inc       ( addr_inc       ),
    .o_busy           ( o_busy         ),
    .o_done           ( o_done         ),
    .o_loop_count     ( o_loop_count   ),
    .o_set_count      ( o_set_count    ),
    .o_clear          ( clear          )
  );

  alg1a_req_issue u_req_issue
  (
    .i_clk         ( i_clk       ),
    .i_arst_n      ( i_arst_n    ),
    .i_phase_start ( phase_start ),
    .i_phase_write ( phase_write ),
    .i_set_base    ( set_base    ),
    .i_pattern     ( pattern     ),
    .i_num_incr    ( num_incr    ),
    .i_addr_inc    ( addr_inc    ),
    .o_mem_req     ( o_mem_req   ),
    .o_req_valid   ( o_req_valid ),
    .i_req_ready   ( i_req_ready )
  );

  alg1a_wr_resp_track u_wr_resp_track
  (
    .i_clk      ( i_clk          ),
    .i_arst_n   ( i_arst_n       ),
    .i_start    ( wr_track_start ),
    .i_clear    ( clear          ),
    .i_num_incr ( num_incr       ),
    .i_wr_resp  ( i_wr_resp      ),
    .o_done     ( wr_done        ),
    .o_slverr   ( slverr         )
  );

  alg1a_rd_check u_rd_check
  (
    .i_clk         ( i_clk          ),
    .i_arst_n      ( i_arst_n       ),
    .i_start       ( rd_check_start ),
    .i_clear       ( clear          ),
    .i_num_incr    ( num_incr       ),
    .i_pattern     ( pattern        ),
    .i_set_base    ( set_base       ),
    .i_addr_inc    ( addr_inc       ),
    .i_rd_resp     ( i_rd_resp      ),
    .o_done        ( rd_done        ),
    .o_set_error   ( set_error      ),
    .o_error_found ( error_found    ),
    .o_error_addr  ( error_addr     ),
    .o_expected    ( expected       ),
    .o_received    ( received       )
  );

  // checker error fields plus the write side slave error flag
  assign o_status = '{error_found: error_found,
                      error_addr:  error_addr,
                      expected:    expected,
                      received:    received,
                      slverr:      slverr};

endmodule

`default_nettype wire

//--- src/alg1a_rd_check.sv
/*
  read response checker for the verify phase
  responses must come back in request order, the address is tracked locally
  only the first mismatch since i_clear is captured
*/
`default_nettype none

module alg1a_rd_check
(
  input  logic                             i_clk,
  input  logic                             i_arst_n,
  input  logic                             i_start,
  input  logic                             i_clear,
  input  logic [alg1a_cfg_pkg::CNT_W-1:0]  i_num_incr,
  input  logic [alg1a_cfg_pkg::DATA_W-1:0] i_pattern,
  input  logic [alg1a_cfg_pkg::ADDR_W-1:0] i_set_base,
  input  logic [alg1a_cfg_pkg::INC_W-1:0]  i_addr_inc,
  input  alg1a_bus_pkg::t_rd_resp          i_rd_resp,
  output logic                             o_done,
  output logic                             o_set_error,
  output logic                             o_error_found,
  output logic [alg1a_cfg_pkg::ADDR_W-1:0] o_error_addr,
  output logic [alg1a_cfg_pkg::DATA_W-1:0] o_expected,
  output logic [alg1a_cfg_pkg::DATA_W-1:0] o_received
);
  import alg1a_cfg_pkg::*;

  logic              active;
  logic [CNT_W-1:0]  cnt;
  logic [ADDR_W-1:0] addr_q;  // address of the next response
  logic              resp;
  logic              mismatch;

  assign resp     = active && i_rd_resp.valid;
  assign mismatch = resp && (i_rd_resp.data != i_pattern);

  always_ff @(posedge i_clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      active        <= 1'b0;
      cnt           <= '0;
      o_done        <= 1'b0;
      o_set_error   <= 1'b0;
      o_error_found <= 1'b0;
      o_error_addr  <= '0;
      o_expected    <= '0;
      o_received    <= '0;
    end
    else
    begin
      o_done <= 1'b0;
      if (i_start)
      begin
        active      <= 1'b1;
        cnt         <= '0;
        o_set_error <= 1'b0;  // per set
      end
      else if (resp)
      begin
        cnt <= cnt + 1'b1;
        if (cnt == CNT_W'(i_num_incr - 1'b1))
        begin
          active <= 1'b0;
          o_done <= 1'b1;
        end
        if (mismatch)
          o_set_error <= 1'b1;  // sequencer samples it with o_done
      end

      if (i_clear)
      begin
        o_error_found <= 1'b0;
        o_error_addr  <= '0;
        o_expected    <= '0;
        o_received    <= '0;
      end
      else if (mismatch && !o_error_found)
      begin
        o_error_found <= 1'b1;  // first one wins
        o_error_addr  <= addr_q;
        o_expected    <= i_pattern;
        o_received    <= i_rd_resp.data;
      end
    end
  end

  always_ff @(posedge i_clk)
  begin
    if (i_start)
      addr_q <= i_set_base;
    else if (resp)
      addr_q <= addr_q + ADDR_W'(i_addr_inc);  // mirrors the issuer
  end

endmodule

`default_nettype wire

//--- src/alg1a_wr_resp_track.sv
/*
  write response counter for the execute phase
  o_slverr is sticky across sets, cleared only by i_clear
*/
`default_nettype none

module alg1a_wr_resp_track
(
  input  logic                            i_clk,
  input  logic                            i_arst_n,
  input  logic                            i_start,
  input  logic                            i_clear,
  input  logic [alg1a_cfg_pkg::CNT_W-1:0] i_num_incr,
  input  alg1a_bus_pkg::t_wr_resp         i_wr_resp,
  output logic                            o_done,
  output logic                            o_slverr
);
  import alg1a_cfg_pkg::*;

  logic             active;
  logic [CNT_W-1:0] cnt;  // responses seen this set

  always_ff @(posedge i_clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      active   <= 1'b0;
      cnt      <= '0;
      o_done   <= 1'b0;
      o_slverr <= 1'b0;
    end
    else
    begin
      o_done <= 1'b0;  // single cycle pulse
      if (i_start)
      begin
        active <= 1'b1;
        cnt    <= '0;
      end
      else if (active && i_wr_resp.valid)
      begin
        cnt <= cnt + 1'b1;
        if (cnt == CNT_W'(i_num_incr - 1'b1))
        begin
          active <= 1'b0;
          o_done <= 1'b1;  // cycle after the N-th response
        end
      end

      if (i_clear)
        o_slverr <= 1'b0;
      else if (i_wr_resp.valid && i_wr_resp.slverr)
        o_slverr <= 1'b1;  // does not stop the run
    end
  end

endmodule

`default_nettype wire

//--- src/alg1a_req_issue.sv
/*
  request issuer shared by the execute and verify phases
  phases never overlap so one stepper serves both
  P and X must hold stable from phase start until the last transfer
*/
`default_nettype none

module alg1a_req_issue
(
  input  logic                             i_clk,
  input  logic                             i_arst_n,
  input  logic                             i_phase_start,
  input  logic                             i_phase_write,
  input  logic [alg1a_cfg_pkg::ADDR_W-1:0] i_set_base,
  input  logic [alg1a_cfg_pkg::DATA_W-1:0] i_pattern,
  input  logic [alg1a_cfg_pkg::CNT_W-1:0]  i_num_incr,
  input  logic [alg1a_cfg_pkg::INC_W-1:0]  i_addr_inc,
  output alg1a_bus_pkg::t_mem_req          o_mem_req,
  output logic                             o_req_valid,
  input  logic                             i_req_ready
);
  import alg1a_cfg_pkg::*;

  logic              active;     // requests outstanding to send
  logic              write_q;    // phase kind
  logic [CNT_W-1:0]  idx;        // transaction index n
  logic [ADDR_W-1:0] addr_q;     // X + n * inc
  logic              xfer;
  logic              last_xfer;

  assign xfer      = active && i_req_ready;
  assign last_xfer = xfer && (idx == CNT_W'(i_num_incr - 1'b1));

  always_ff @(posedge i_clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      active  <= 1'b0;
      write_q <= 1'b0;
      idx     <= '0;
    end
    else if (i_phase_start)
    begin
      active  <= 1'b1;  // valid one cycle later
      write_q <= i_phase_write;
      idx     <= '0;
    end
    else if (xfer)
    begin
      idx <= idx + 1'b1;
      if (last_xfer)
        active <= 1'b0;  // N-th request accepted
    end
  end

  // address stepper advances after each transfer
  always_ff @(posedge i_clk)
  begin
    if (i_phase_start)
      addr_q <= i_set_base;
    else if (xfer)
      addr_q <= addr_q + ADDR_W'(i_addr_inc);
  end

  assign o_req_valid = active;

  always_comb
  begin
    o_mem_req.is_write = write_q;
    o_mem_req.addr     = addr_q;
    o_mem_req.data     = write_q ? i_pattern : '0;  // reads carry no data
  end

endmodule

`default_nettype wire

//--- src/alg1a_seq_fsm.sv
/*
  loop and set sequencer
  start is taken only while idle or in the done cycle
  X is kept as a running sum of set_offset, no multiplier
  at done without error the counts read the configured totals
  after an error they hold the loop and set that failed
*/
`default_nettype none

module alg1a_seq_fsm
(
  input  logic                             i_clk,
  input  logic                             i_arst_n,
  input  logic                             i_start,
  input  alg1a_cfg_pkg::t_alg_cfg          i_cfg,
  input  logic                             i_wr_done,
  input  logic                             i_rd_done,
  input  logic                             i_set_error,
  output logic                             o_phase_start,
  output logic                             o_phase_write,
  output logic                             o_wr_track_start,
  output logic                             o_rd_check_start,
  output logic [alg1a_cfg_pkg::DATA_W-1:0] o_pattern,
  output logic [alg1a_cfg_pkg::ADDR_W-1:0] o_set_base,
  output logic [alg1a_cfg_pkg::CNT_W-1:0]  o_num_incr,
  output logic [alg1a_cfg_pkg::INC_W-1:0]  o_addr_inc,
  output logic                             o_busy,
  output logic                             o_done,
  output logic [alg1a_cfg_pkg::CNT_W-1:0]  o_loop_count,
  output logic [alg1a_cfg_pkg::CNT_W-1:0]  o_set_count,
  output logic                             o_clear
);
  import alg1a_cfg_pkg::*;

  typedef enum logic [2:0] {ST_IDLE, ST_NEXT, ST_EXEC, ST_VERIFY, ST_FINISH} t_seq_state;

  t_seq_state       state;
  t_alg_cfg         cfg_q;       // registered at start
  logic             idle_st;
  logic             start_ok;
  logic             rd_start_q;  // verify phase kick
  logic             last_set;
  logic             last_loop;
  logic             set_pass;    // set finished clean

  assign idle_st  = (state == ST_IDLE) || (state == ST_FINISH);
  assign start_ok = i_start && idle_st;
  assign o_clear  = start_ok;  // wipes sticky status
  assign o_busy   = !idle_st;  // low in the done cycle
  assign o_done   = (state == ST_FINISH);

  assign last_set  = (o_set_count == CNT_W'(eff_cnt(cfg_q.num_sets) - 1'b1));
  assign last_loop = (o_loop_count == CNT_W'(eff_cnt(cfg_q.num_loops) - 1'b1));
  assign set_pass  = (state == ST_VERIFY) && i_rd_done && !i_set_error;

  // execute phase opens from NEXT, verify from the registered kick
  assign o_phase_start    = (state == ST_NEXT) || rd_start_q;
  assign o_phase_write    = (state == ST_NEXT) || (state == ST_EXEC);
  assign o_wr_track_start = (state == ST_NEXT);
  assign o_rd_check_start = rd_start_q;

  assign o_num_incr = eff_cnt(cfg_q.num_incr);
  assign o_addr_inc = cfg_q.addr_inc;
  assign o_pattern  = cfg_q.pattern_param ? cfg_q.base_pattern + DATA_W'(o_loop_count)
                                          : cfg_q.base_pattern;

  always_ff @(posedge i_clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      state        <= ST_IDLE;
      rd_start_q   <= 1'b0;
      o_loop_count <= '0;
      o_set_count  <= '0;
    end
    else
    begin
      rd_start_q <= 1'b0;
      case (state)
        ST_IDLE, ST_FINISH:
        begin
          state <= ST_IDLE;
          if (i_start)
          begin
            state        <= ST_NEXT;
            o_loop_count <= '0;
            o_set_count  <= '0;
          end
        end
        ST_NEXT: state <= ST_EXEC;  // phase start goes out in this one cycle
        ST_EXEC:
        begin
          if (i_wr_done)
          begin
            state      <= ST_VERIFY;
            rd_start_q <= 1'b1;
          end
        end
        ST_VERIFY:
        begin
          if (i_rd_done)
          begin
            if (i_set_error)
              state <= ST_FINISH;  // counts stay on the bad set
            else if (last_set && last_loop)
            begin
              state        <= ST_FINISH;
              o_set_count  <= o_set_count + 1'b1;   // totals at done
              o_loop_count <= o_loop_count + 1'b1;
            end
            else if (last_set)
            begin
              state        <= ST_NEXT;
              o_set_count  <= '0;
              o_loop_count <= o_loop_count + 1'b1;
            end
            else
            begin
              state       <= ST_NEXT;
              o_set_count <= o_set_count + 1'b1;
            end
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // config copy and X
  always_ff @(posedge i_clk)
  begin
    if (start_ok)
    begin
      cfg_q      <= i_cfg;
      o_set_base <= i_cfg.base_addr;
    end
    else if (set_pass)
    begin
      if (last_set)
        o_set_base <= cfg_q.base_addr;  // new loop restarts at set 0
      else
        o_set_base <= o_set_base + cfg_q.set_offset;
    end
  end

endmodule

`default_nettype wire

//--- src/alg1a_bus_pkg.sv
/*
  memory bus channel types
  requests use a valid/ready handshake
  responses return in request order, one cycle valid, no ready
*/
`default_nettype none

package alg1a_bus_pkg;

  import alg1a_cfg_pkg::*;

  // one word per request, data is zero on reads
  typedef struct packed {
    logic              is_write;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
  } t_mem_req;

  typedef struct packed {
    logic valid;
    logic slverr;  // slave error on this write
  } t_wr_resp;

  typedef struct packed {
    logic              valid;
    logic [DATA_W-1:0] data;
  } t_rd_resp;

endpackage

`default_nettype wire

//--- src/alg1a_cfg_pkg.sv
/*
  configuration and status types for the algorithm 1a engine
  a count field of 0 runs as 1 (see eff_cnt)
  addresses and data are one 32 bit word per beat
*/
`default_nettype none

package alg1a_cfg_pkg;

  localparam int ADDR_W = 32;  // byte address
  localparam int DATA_W = 32;  // data word and pattern
  localparam int CNT_W  = 8;   // increment, set and loop counts
  localparam int INC_W  = 16;  // address increment field

  // sampled at start, held for the whole run
  typedef struct packed {
    logic [ADDR_W-1:0] base_addr;
    logic [DATA_W-1:0] base_pattern;
    logic [INC_W-1:0]  addr_inc;
    logic [ADDR_W-1:0] set_offset;     // step of X between sets
    logic [CNT_W-1:0]  num_incr;       // N
    logic [CNT_W-1:0]  num_sets;
    logic [CNT_W-1:0]  num_loops;
    logic              pattern_param;  // P grows by one per loop
  } t_alg_cfg;

  // valid from done until the next start
  typedef struct packed {
    logic              error_found;
    logic [ADDR_W-1:0] error_addr;
    logic [DATA_W-1:0] expected;
    logic [DATA_W-1:0] received;
    logic              slverr;  // sticky, any write response
  } t_alg_status;

  // zero count runs once
  function automatic logic [CNT_W-1:0] eff_cnt(input logic [CNT_W-1:0] cnt);
    return (cnt == '0) ? CNT_W'(1) : cnt;
  endfunction

endpackage

`default_nettype wire
